/* common/rv_isa_pkg.sv */
////////////////////////////////////////
// RV32I instruction set definitions
////////////////////////////////////////

`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] word_t;      // Data or address word
    typedef logic [4:0]  reg_addr_t;  // GPR index
    typedef logic [6:0]  opcode_t;    // Major opcode
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // R-type layout, the other formats share these positions
    typedef struct packed {
        funct7_t   funct7;
        reg_addr_t rs2;
        reg_addr_t rs1;
        funct3_t   funct3;
        reg_addr_t rd;
        opcode_t   opcode;
    } insn_fmt_t;

    ////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////
    localparam opcode_t OP_LD    = 7'b000_0011;
    localparam opcode_t OP_ST    = 7'b010_0011;
    localparam opcode_t OP_JAL   = 7'b110_1111;
    localparam opcode_t OP_JALR  = 7'b110_0111;
    localparam opcode_t OP_BR    = 7'b110_0011;
    localparam opcode_t OP_ALSI  = 7'b001_0011;  // ALU with immediate
    localparam opcode_t OP_ALS   = 7'b011_0011;  // ALU register-register
    localparam opcode_t OP_LUI   = 7'b011_0111;
    localparam opcode_t OP_AUIPC = 7'b001_0111;

    ////////////////////////////////////////
    // funct3 per group
    ////////////////////////////////////////
    localparam funct3_t F3_LB   = 3'd0;
    localparam funct3_t F3_LH   = 3'd1;
    localparam funct3_t F3_LW   = 3'd2;
    localparam funct3_t F3_LBU  = 3'd4;
    localparam funct3_t F3_LHU  = 3'd5;

    localparam funct3_t F3_SB   = 3'd0;
    localparam funct3_t F3_SH   = 3'd1;
    localparam funct3_t F3_SW   = 3'd2;

    localparam funct3_t F3_BEQ  = 3'd0;
    localparam funct3_t F3_BNE  = 3'd1;
    localparam funct3_t F3_BLT  = 3'd4;
    localparam funct3_t F3_BGE  = 3'd5;
    localparam funct3_t F3_BLTU = 3'd6;
    localparam funct3_t F3_BGEU = 3'd7;

    // Shared by register and immediate forms
    localparam funct3_t F3_ADD  = 3'd0;  // ADD, SUB, ADDI
    localparam funct3_t F3_SLL  = 3'd1;
    localparam funct3_t F3_SLT  = 3'd2;
    localparam funct3_t F3_SLTU = 3'd3;
    localparam funct3_t F3_XOR  = 3'd4;
    localparam funct3_t F3_SR   = 3'd5;  // SRL or SRA by funct7
    localparam funct3_t F3_OR   = 3'd6;
    localparam funct3_t F3_AND  = 3'd7;

    localparam funct7_t F7_BASE = 7'b000_0000;
    localparam funct7_t F7_ALT  = 7'b010_0000;  // SUB, SRA

endpackage

`default_nettype wire

/* common/decode_pkg.sv */
////////////////////////////////////////
// Decode types and pipeline structs
////////////////////////////////////////

`default_nettype none

package decode_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_XOR, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        CMP_NOP, CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU
    } cmp_op_e;

    typedef enum logic [3:0] {
        MEM_NOP, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    // Which EX result goes to the GPR
    typedef enum logic [1:0] {EX_OUT_ALU, EX_OUT_CMP, EX_OUT_PCN} ex_out_sel_e;

    typedef logic [3:0] exp_code_t;
    localparam exp_code_t EXP_NONE    = 4'h0;
    localparam exp_code_t EXP_ILLEGAL = 4'h2;  // mcause value

    typedef enum logic {SRC0_RS1, SRC0_PC} src0_sel_e;
    typedef enum logic [2:0] {
        SRC1_RS2, SRC1_IMM_I, SRC1_IMM_IR, SRC1_IMM_S, SRC1_IMM_B, SRC1_IMM_J, SRC1_IMM_U
    } src1_sel_e;
    typedef enum logic {WB_NPC, WB_IMM_U} wb_sel_e;

    typedef struct packed {
        word_t imm_i;
        word_t imm_ir;  // Shift amount
        word_t imm_s;
        word_t imm_b;
        word_t imm_j;
        word_t imm_u;
    } imm_set_t;

    typedef struct packed {
        alu_op_e     alu_op;
        cmp_op_e     cmp_op;
        mem_op_e     mem_op;
        ex_out_sel_e ex_out_sel;
        src0_sel_e   src0_sel;
        src1_sel_e   src1_sel;
        logic        cmp1_imm;  // Compare against imm_i
        wb_sel_e     wb_sel;
        logic        gpr_we;
        logic        jump_taken;
        logic        is_jalr;
        exp_code_t   exp_code;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        alu_op_e     alu_op;
        word_t       alu_in_0;
        word_t       alu_in_1;
        cmp_op_e     cmp_op;
        word_t       cmp_in_0;
        word_t       cmp_in_1;
        logic        jump_taken;
        logic        is_jalr;
        mem_op_e     mem_op;
        word_t       mem_wr_data;
        ex_out_sel_e ex_out_sel;
        word_t       gpr_wr_data;
        reg_addr_t   rd_addr;
        logic        gpr_we;
        exp_code_t   exp_code;
    } id_ex_t;

    // No-op control word
    localparam ctrl_t CTRL_BUBBLE = '{
        alu_op: ALU_NOP, cmp_op: CMP_NOP, mem_op: MEM_NOP, ex_out_sel: EX_OUT_ALU,
        src0_sel: SRC0_RS1, src1_sel: SRC1_RS2, cmp1_imm: 1'b0, wb_sel: WB_NPC,
        gpr_we: 1'b0, jump_taken: 1'b0, is_jalr: 1'b0, exp_code: EXP_NONE
    };

    localparam id_ex_t ID_EX_BUBBLE = '{
        valid: 1'b0, alu_op: ALU_NOP, alu_in_0: '0, alu_in_1: '0,
        cmp_op: CMP_NOP, cmp_in_0: '0, cmp_in_1: '0, jump_taken: 1'b0,
        is_jalr: 1'b0, mem_op: MEM_NOP, mem_wr_data: '0, ex_out_sel: EX_OUT_ALU,
        gpr_wr_data: '0, rd_addr: '0, gpr_we: 1'b0, exp_code: EXP_NONE
    };

endpackage

`default_nettype wire

/* hw/decoder/imm_gen.sv */
////////////////////////////////////////
// Immediate generator
////////////////////////////////////////

`default_nettype none

module imm_gen (
    input  rv_isa_pkg::word_t    insn,  // Fetched instruction
    output decode_pkg::imm_set_t imm    // All immediate formats
);

    import rv_isa_pkg::*;

    word_t sign_hi;  // Bit 31 replicated

    assign sign_hi = {32{insn[31]}};

    ////////////////////////////////////////
    // Formats
    ////////////////////////////////////////

    // I type, loads / JALR / ALU immediates
    assign imm.imm_i  = {sign_hi[31:12], insn[31:20]};

    // Shift amount only, upper bits follow bit 31
    assign imm.imm_ir = {sign_hi[31:5], insn[24:20]};

    // S type, offset split around rd position
    assign imm.imm_s  = {sign_hi[31:12], insn[31:25], insn[11:7]};

    // B type, half-word aligned
    assign imm.imm_b  = {sign_hi[31:12],
                         insn[7],          // Bit 11
                         insn[30:25],
                         insn[11:8],
                         1'b0};

    // J type, 21-bit reach
    assign imm.imm_j  = {sign_hi[31:20],
                         insn[19:12],
                         insn[20],         // Bit 11
                         insn[30:21],
                         1'b0};

    // U type, low 12 bits cleared
    assign imm.imm_u  = {insn[31:12], 12'h000};

endmodule

`default_nettype wire

/* hw/decoder/ctrl_decode.sv */
////////////////////////////////////////
// Control field decoder
////////////////////////////////////////

`default_nettype none

module ctrl_decode (
    input  rv_isa_pkg::word_t insn,   // Fetched instruction
    input  logic              if_en,  // Instruction valid
    output decode_pkg::ctrl_t ctrl
);

    import rv_isa_pkg::*;
    import decode_pkg::*;

    insn_fmt_t fmt;

    assign fmt = insn;

    always_comb begin
        ctrl = CTRL_BUBBLE;  // Defaults, also the bubble
        if (if_en) begin
            case (fmt.opcode)
                ////////////////////////////////////////
                // Loads and stores
                ////////////////////////////////////////
                OP_LD: begin
                    ctrl.alu_op   = ALU_ADD;     // Address = rs1 + imm
                    ctrl.src1_sel = SRC1_IMM_I;
                    ctrl.gpr_we   = 1'b1;
                    case (fmt.funct3)
                        F3_LB:   ctrl.mem_op = MEM_LB;
                        F3_LH:   ctrl.mem_op = MEM_LH;
                        F3_LW:   ctrl.mem_op = MEM_LW;
                        F3_LBU:  ctrl.mem_op = MEM_LBU;
                        F3_LHU:  ctrl.mem_op = MEM_LHU;
                        default: ctrl.exp_code = EXP_ILLEGAL;
                    endcase
                end
                OP_ST: begin
                    ctrl.alu_op   = ALU_ADD;
                    ctrl.src1_sel = SRC1_IMM_S;
                    case (fmt.funct3)
                        F3_SB:   ctrl.mem_op = MEM_SB;
                        F3_SH:   ctrl.mem_op = MEM_SH;
                        F3_SW:   ctrl.mem_op = MEM_SW;
                        default: ctrl.exp_code = EXP_ILLEGAL;
                    endcase
                end

                ////////////////////////////////////////
                // Jumps and branches
                ////////////////////////////////////////
                OP_JALR: begin
                    ctrl.alu_op     = ALU_ADD;     // Target = rs1 + imm
                    ctrl.src1_sel   = SRC1_IMM_I;
                    ctrl.gpr_we     = 1'b1;
                    ctrl.is_jalr    = 1'b1;
                    ctrl.jump_taken = 1'b1;
                    ctrl.ex_out_sel = EX_OUT_PCN;  // Link value npc
                end
                OP_JAL: begin
                    ctrl.alu_op     = ALU_ADD;
                    ctrl.src0_sel   = SRC0_PC;
                    ctrl.src1_sel   = SRC1_IMM_J;
                    ctrl.gpr_we     = 1'b1;
                    ctrl.jump_taken = 1'b1;
                    ctrl.ex_out_sel = EX_OUT_PCN;
                end
                OP_BR: begin
                    // ALU forms the target, comparator decides
                    ctrl.alu_op   = ALU_ADD;
                    ctrl.src0_sel = SRC0_PC;
                    ctrl.src1_sel = SRC1_IMM_B;
                    case (fmt.funct3)
                        F3_BEQ:  ctrl.cmp_op = CMP_EQ;
                        F3_BNE:  ctrl.cmp_op = CMP_NE;
                        F3_BLT:  ctrl.cmp_op = CMP_LT;
                        F3_BGE:  ctrl.cmp_op = CMP_GE;
                        F3_BLTU: ctrl.cmp_op = CMP_LTU;
                        F3_BGEU: ctrl.cmp_op = CMP_GEU;
                        default: ctrl.exp_code = EXP_ILLEGAL;  // funct3 2, 3
                    endcase
                end

                ////////////////////////////////////////
                // ALU operations
                ////////////////////////////////////////
                OP_ALSI: begin
                    ctrl.gpr_we   = 1'b1;
                    ctrl.src1_sel = SRC1_IMM_I;
                    case (fmt.funct3)
                        F3_ADD:  ctrl.alu_op = ALU_ADD;
                        F3_SLL:  ctrl.alu_op = ALU_SLL;   // Low 5 bits of imm_i
                        F3_XOR:  ctrl.alu_op = ALU_XOR;
                        F3_OR:   ctrl.alu_op = ALU_OR;
                        F3_AND:  ctrl.alu_op = ALU_AND;
                        F3_SLT, F3_SLTU: begin
                            ctrl.cmp_op     = (fmt.funct3 == F3_SLT) ? CMP_LT : CMP_LTU;
                            ctrl.cmp1_imm   = 1'b1;
                            ctrl.ex_out_sel = EX_OUT_CMP;
                        end
                        F3_SR: begin
                            ctrl.src1_sel = SRC1_IMM_IR;
                            case (fmt.funct7)
                                F7_BASE: ctrl.alu_op = ALU_SRL;
                                F7_ALT:  ctrl.alu_op = ALU_SRA;
                                default: ctrl.exp_code = EXP_ILLEGAL;
                            endcase
                        end
                        default: ctrl.exp_code = EXP_ILLEGAL;
                    endcase
                end
                OP_ALS: begin
                    ctrl.gpr_we = 1'b1;  // Operands rs1, rs2 by default
                    case (fmt.funct3)
                        F3_ADD: begin
                            case (fmt.funct7)
                                F7_BASE: ctrl.alu_op = ALU_ADD;
                                F7_ALT:  ctrl.alu_op = ALU_SUB;
                                default: ctrl.exp_code = EXP_ILLEGAL;
                            endcase
                        end
                        F3_SLL:  ctrl.alu_op = ALU_SLL;
                        F3_XOR:  ctrl.alu_op = ALU_XOR;
                        F3_OR:   ctrl.alu_op = ALU_OR;
                        F3_AND:  ctrl.alu_op = ALU_AND;
                        F3_SLT, F3_SLTU: begin
                            ctrl.cmp_op     = (fmt.funct3 == F3_SLT) ? CMP_LT : CMP_LTU;
                            ctrl.ex_out_sel = EX_OUT_CMP;
                        end
                        F3_SR: begin
                            case (fmt.funct7)
                                F7_BASE: ctrl.alu_op = ALU_SRL;
                                F7_ALT:  ctrl.alu_op = ALU_SRA;
                                default: ctrl.exp_code = EXP_ILLEGAL;
                            endcase
                        end
                        default: ctrl.exp_code = EXP_ILLEGAL;
                    endcase
                end

                // Upper immediates
                OP_LUI: begin
                    ctrl.gpr_we     = 1'b1;
                    ctrl.wb_sel     = WB_IMM_U;    // Passes through as PCN
                    ctrl.ex_out_sel = EX_OUT_PCN;
                end
                OP_AUIPC: begin
                    ctrl.alu_op   = ALU_ADD;
                    ctrl.src0_sel = SRC0_PC;
                    ctrl.src1_sel = SRC1_IMM_U;
                    ctrl.gpr_we   = 1'b1;
                end
                default: ctrl.exp_code = EXP_ILLEGAL;  // Unknown opcode
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/decoder/operand_mux.sv */
////////////////////////////////////////
// Operand selection
////////////////////////////////////////

`default_nettype none

module operand_mux (
    input  decode_pkg::ctrl_t    ctrl,
    input  decode_pkg::imm_set_t imm,
    input  rv_isa_pkg::word_t    pc,
    input  rv_isa_pkg::word_t    npc,
    input  rv_isa_pkg::word_t    rs1_data,
    input  rv_isa_pkg::word_t    rs2_data,
    input  rv_isa_pkg::reg_addr_t rd_addr,
    output decode_pkg::id_ex_t   next
);

    import decode_pkg::*;

    // ALU second operand
    always_comb begin
        case (ctrl.src1_sel)
            SRC1_IMM_I:  next.alu_in_1 = imm.imm_i;
            SRC1_IMM_IR: next.alu_in_1 = imm.imm_ir;
            SRC1_IMM_S:  next.alu_in_1 = imm.imm_s;
            SRC1_IMM_B:  next.alu_in_1 = imm.imm_b;
            SRC1_IMM_J:  next.alu_in_1 = imm.imm_j;
            SRC1_IMM_U:  next.alu_in_1 = imm.imm_u;
            default:     next.alu_in_1 = rs2_data;
        endcase
    end

    ////////////////////////////////////////
    // Data path
    ////////////////////////////////////////
    assign next.alu_in_0    = (ctrl.src0_sel == SRC0_PC) ? pc : rs1_data;
    assign next.cmp_in_0    = rs1_data;
    assign next.cmp_in_1    = ctrl.cmp1_imm ? imm.imm_i : rs2_data;
    assign next.mem_wr_data = rs2_data;  // Store data
    assign next.gpr_wr_data = (ctrl.wb_sel == WB_IMM_U) ? imm.imm_u : npc;
    assign next.rd_addr     = rd_addr;

    // Control copied through
    assign next.alu_op      = ctrl.alu_op;
    assign next.cmp_op      = ctrl.cmp_op;
    assign next.mem_op      = ctrl.mem_op;
    assign next.ex_out_sel  = ctrl.ex_out_sel;
    assign next.jump_taken  = ctrl.jump_taken;
    assign next.is_jalr     = ctrl.is_jalr;
    assign next.gpr_we      = ctrl.gpr_we;
    assign next.exp_code    = ctrl.exp_code;
    assign next.valid       = 1'b0;  // Replaced by the ID/EX register

endmodule

`default_nettype wire

/* hw/id_ex_reg.sv */
////////////////////////////////////////
// ID/EX pipeline register
////////////////////////////////////////

`default_nettype none

module id_ex_reg (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               if_en,  // Stage holds a valid instruction
    input  decode_pkg::id_ex_t next,
    output decode_pkg::id_ex_t id_ex
);

    import decode_pkg::*;

    // One result per cycle, no stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= ID_EX_BUBBLE;
        end else begin
            id_ex       <= next;   // Ops already NOP when if_en low
            id_ex.valid <= if_en;
        end
    end

endmodule

`default_nettype wire

/* hw/id_stage.sv */
////////////////////////////////////////
// Instruction decode stage
////////////////////////////////////////

`default_nettype none

module id_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_isa_pkg::word_t     pc,        // PC of insn
    input  rv_isa_pkg::word_t     npc,       // Link address
    input  rv_isa_pkg::word_t     insn,
    input  logic                  if_en,     // Fetch output valid
    input  rv_isa_pkg::word_t     rs1_data,  // From register file
    input  rv_isa_pkg::word_t     rs2_data,
    output rv_isa_pkg::reg_addr_t rs1_addr,  // To register file
    output rv_isa_pkg::reg_addr_t rs2_addr,
    output decode_pkg::id_ex_t    id_ex
);

    import rv_isa_pkg::*;
    import decode_pkg::*;

    insn_fmt_t fmt;
    imm_set_t  imm;
    ctrl_t     ctrl;
    id_ex_t    next;   // Unregistered decode result

    ////////////////////////////////////////
    // Register file addresses
    ////////////////////////////////////////
    assign fmt      = insn;
    assign rs1_addr = fmt.rs1;  // Zero-cycle path
    assign rs2_addr = fmt.rs2;

    imm_gen u_imm_gen (
        .insn (insn),
        .imm  (imm)
    );

    ctrl_decode u_ctrl_decode (
        .insn  (insn),
        .if_en (if_en),
        .ctrl  (ctrl)
    );

    operand_mux u_operand_mux (
        .ctrl     (ctrl),
        .imm      (imm),
        .pc       (pc),
        .npc      (npc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd_addr  (fmt.rd),
        .next     (next)
    );

    id_ex_reg u_id_ex_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .if_en (if_en),
        .next  (next),
        .id_ex (id_ex)
    );

endmodule

`default_nettype wire

/* test/tb_clock.sv */
////////////////////////////////////////
// Testbench clock and reset
////////////////////////////////////////

`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    // Low for 5 cycles, released just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* test/tb_id_stage.sv */
////////////////////////////////////////
// Decode stage testbench
////////////////////////////////////////

`default_nettype none

module tb_id_stage;

    timeunit 1ns;
    timeprecision 100ps;

    import rv_isa_pkg::*;
    import decode_pkg::*;

    logic      clk;
    logic      rst_n;
    word_t     pc;
    word_t     npc;
    word_t     insn;
    logic      if_en;
    word_t     rs1_data;
    word_t     rs2_data;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    id_ex_t    id_ex;

    id_ex_t      exp_q;          // Reference result, one cycle behind
    integer      seed = 32'h7403_01e7;

    // Legal funct3 choices per group
    funct3_t load_f3   [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    funct3_t branch_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    opcode_t bad_opcode[4] = '{7'h00, 7'h7f, 7'h73, 7'h0f};  // SYSTEM and FENCE not decoded

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    id_stage uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .pc       (pc),
        .npc      (npc),
        .insn     (insn),
        .if_en    (if_en),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .id_ex    (id_ex)
    );

    ////////////////////////////////////////
    // Reference decode
    ////////////////////////////////////////
    function automatic id_ex_t expected_decode(
        input word_t i,
        input word_t pc_v,
        input word_t npc_v,
        input logic  en,
        input word_t rs1,
        input word_t rs2
    );
        id_ex_t     e;
        word_t      imm_i, imm_sh, imm_s, imm_b, imm_j, imm_u;
        logic [2:0] f3;
        logic [6:0] f7;
        imm_i  = {{20{i[31]}}, i[31:20]};
        imm_sh = {{27{i[31]}}, i[24:20]};                 // Shift amount
        imm_s  = {{20{i[31]}}, i[31:25], i[11:7]};
        imm_b  = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        imm_j  = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        imm_u  = {i[31:12], 12'h000};
        f3     = i[14:12];
        f7     = i[31:25];

        // Neutral operands, also what an idle cycle carries
        e             = '0;
        e.valid       = en;
        e.alu_in_0    = rs1;
        e.alu_in_1    = rs2;
        e.cmp_in_0    = rs1;
        e.cmp_in_1    = rs2;
        e.mem_wr_data = rs2;
        e.gpr_wr_data = npc_v;
        e.rd_addr     = i[11:7];
        if (!en)
            return e;

        case (i[6:0])
            OP_LD: begin
                e.alu_op   = ALU_ADD;
                e.alu_in_1 = imm_i;
                e.gpr_we   = 1'b1;
                case (f3)
                    3'd0:    e.mem_op = MEM_LB;
                    3'd1:    e.mem_op = MEM_LH;
                    3'd2:    e.mem_op = MEM_LW;
                    3'd4:    e.mem_op = MEM_LBU;
                    3'd5:    e.mem_op = MEM_LHU;
                    default: e.exp_code = EXP_ILLEGAL;
                endcase
            end
            OP_ST: begin
                e.alu_op   = ALU_ADD;
                e.alu_in_1 = imm_s;
                case (f3)
                    3'd0:    e.mem_op = MEM_SB;
                    3'd1:    e.mem_op = MEM_SH;
                    3'd2:    e.mem_op = MEM_SW;
                    default: e.exp_code = EXP_ILLEGAL;
                endcase
            end
            OP_JALR: begin
                e.alu_op     = ALU_ADD;
                e.alu_in_1   = imm_i;
                e.gpr_we     = 1'b1;
                e.jump_taken = 1'b1;
                e.is_jalr    = 1'b1;
                e.ex_out_sel = EX_OUT_PCN;
            end
            OP_JAL: begin
                e.alu_op     = ALU_ADD;
                e.alu_in_0   = pc_v;
                e.alu_in_1   = imm_j;
                e.gpr_we     = 1'b1;
                e.jump_taken = 1'b1;
                e.ex_out_sel = EX_OUT_PCN;
            end
            OP_BR: begin
                e.alu_op   = ALU_ADD;     // Branch target
                e.alu_in_0 = pc_v;
                e.alu_in_1 = imm_b;
                case (f3)
                    3'd0:    e.cmp_op = CMP_EQ;
                    3'd1:    e.cmp_op = CMP_NE;
                    3'd4:    e.cmp_op = CMP_LT;
                    3'd5:    e.cmp_op = CMP_GE;
                    3'd6:    e.cmp_op = CMP_LTU;
                    3'd7:    e.cmp_op = CMP_GEU;
                    default: e.exp_code = EXP_ILLEGAL;
                endcase
            end
            OP_ALS, OP_ALSI: begin
                e.gpr_we = 1'b1;
                if (i[6:0] == OP_ALSI)
                    e.alu_in_1 = (f3 == 3'd1 || f3 == 3'd5) ? imm_sh : imm_i;
                case (f3)
                    3'd0: begin
                        if (i[6:0] == OP_ALSI || f7 == 7'h00)
                            e.alu_op = ALU_ADD;
                        else if (f7 == 7'h20)
                            e.alu_op = ALU_SUB;
                        else
                            e.exp_code = EXP_ILLEGAL;
                    end
                    3'd1: e.alu_op = ALU_SLL;
                    3'd2, 3'd3: begin
                        e.cmp_op     = (f3 == 3'd2) ? CMP_LT : CMP_LTU;
                        e.ex_out_sel = EX_OUT_CMP;
                        if (i[6:0] == OP_ALSI)
                            e.cmp_in_1 = imm_i;
                    end
                    3'd4: e.alu_op = ALU_XOR;
                    3'd5: begin
                        if (f7 == 7'h00)
                            e.alu_op = ALU_SRL;
                        else if (f7 == 7'h20)
                            e.alu_op = ALU_SRA;
                        else
                            e.exp_code = EXP_ILLEGAL;
                    end
                    3'd6: e.alu_op = ALU_OR;
                    default: e.alu_op = ALU_AND;
                endcase
            end
            OP_LUI: begin
                e.gpr_we      = 1'b1;
                e.gpr_wr_data = imm_u;
                e.ex_out_sel  = EX_OUT_PCN;
            end
            OP_AUIPC: begin
                e.alu_op   = ALU_ADD;
                e.alu_in_0 = pc_v;
                e.alu_in_1 = imm_u;
                e.gpr_we   = 1'b1;
            end
            default: e.exp_code = EXP_ILLEGAL;
        endcase
        return e;
    endfunction

    ////////////////////////////////////////
    // Checking
    ////////////////////////////////////////
    task automatic stop_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got === want) else begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, want);
            stop_with_failure();
        end
    endtask

    // Expected register contents
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            exp_q <= '0;
        else
            exp_q <= expected_decode(insn, pc, npc, if_en, rs1_data, rs2_data);
    end

    // Outputs are settled mid-cycle
    always @(negedge clk) begin
        check_field("rs1_addr", rs1_addr, insn[19:15]);
        check_field("rs2_addr", rs2_addr, insn[24:20]);
        check_field("valid", id_ex.valid, exp_q.valid);
        check_field("alu_op", id_ex.alu_op, exp_q.alu_op);
        check_field("alu_in_0", id_ex.alu_in_0, exp_q.alu_in_0);
        check_field("alu_in_1", id_ex.alu_in_1, exp_q.alu_in_1);
        check_field("cmp_op", id_ex.cmp_op, exp_q.cmp_op);
        check_field("cmp_in_0", id_ex.cmp_in_0, exp_q.cmp_in_0);
        check_field("cmp_in_1", id_ex.cmp_in_1, exp_q.cmp_in_1);
        check_field("jump_taken", id_ex.jump_taken, exp_q.jump_taken);
        check_field("is_jalr", id_ex.is_jalr, exp_q.is_jalr);
        check_field("mem_op", id_ex.mem_op, exp_q.mem_op);
        check_field("mem_wr_data", id_ex.mem_wr_data, exp_q.mem_wr_data);
        check_field("ex_out_sel", id_ex.ex_out_sel, exp_q.ex_out_sel);
        check_field("gpr_wr_data", id_ex.gpr_wr_data, exp_q.gpr_wr_data);
        check_field("rd_addr", id_ex.rd_addr, exp_q.rd_addr);
        check_field("gpr_we", id_ex.gpr_we, exp_q.gpr_we);
        check_field("exp_code", id_ex.exp_code, exp_q.exp_code);
    end

    // One instruction per cycle, 1 ns after the edge
    task automatic drive(input word_t word, input logic en);
        @(posedge clk);
        #1;
        insn     = word;
        if_en    = en;
        pc       = $random(seed) & 32'hffff_fffc;
        npc      = pc + 32'd4;
        rs1_data = $random(seed);
        rs2_data = $random(seed);
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        word_t       rnd;
        funct3_t     f3;
        funct7_t     f7;
        int unsigned wait_cnt;
        int          k;

        insn     = '0;
        pc       = '0;
        npc      = '0;
        if_en    = 1'b0;
        rs1_data = '0;
        rs2_data = '0;

        wait_cnt = 0;
        while (rst_n !== 1'b1 && wait_cnt < 20) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was not released within 20 cycles");
            stop_with_failure();
        end

        repeat (4) drive($random(seed), 1'b0);  // Idle cycles give bubbles

        // Register and immediate ALU forms
        for (k = 0; k < 40; k++) begin
            rnd = $random(seed);
            f3  = rnd[14:12];
            f7  = ((f3 == 3'd0 || f3 == 3'd5) && rnd[30]) ? F7_ALT : F7_BASE;
            drive({f7, rnd[24:15], f3, rnd[11:7], OP_ALS}, 1'b1);
            rnd = $random(seed);
            f3  = rnd[14:12];
            if (f3 == 3'd1 || f3 == 3'd5)
                rnd[31:25] = (f3 == 3'd5 && rnd[30]) ? F7_ALT : F7_BASE;
            drive({rnd[31:15], f3, rnd[11:7], OP_ALSI}, 1'b1);
            if (rnd[3:2] == 2'b00)
                drive($random(seed), 1'b0);
        end

        // Loads and stores
        for (k = 0; k < 30; k++) begin
            rnd = $random(seed);
            f3  = load_f3[rnd % 5];
            drive({rnd[31:15], f3, rnd[11:7], OP_LD}, 1'b1);
            rnd = $random(seed);
            f3  = rnd % 3;
            drive({rnd[31:15], f3, rnd[11:7], OP_ST}, 1'b1);
        end

        // Jumps, branches, upper immediates
        for (k = 0; k < 30; k++) begin
            rnd = $random(seed);
            drive({rnd[31:7], OP_JAL}, 1'b1);
            drive({rnd[31:15], 3'd0, rnd[11:7], OP_JALR}, 1'b1);
            f3  = branch_f3[rnd % 6];
            drive({rnd[31:15], f3, rnd[11:7], OP_BR}, 1'b1);
            rnd = $random(seed);
            drive({rnd[31:7], OP_LUI}, 1'b1);
            drive({rnd[31:7], OP_AUIPC}, 1'b1);
        end

        // Illegal encodings
        for (k = 0; k < 8; k++) begin
            rnd = $random(seed);
            f7  = rnd[31:25] | 7'h40;  // Neither base nor alternate
            foreach (bad_opcode[j])
                drive({rnd[31:7], bad_opcode[j]}, 1'b1);
            drive({rnd[31:15], 2'b01, rnd[0], rnd[11:7], OP_BR}, 1'b1);
            drive({rnd[31:15], 3'd3, rnd[11:7], OP_LD}, 1'b1);
            drive({f7, rnd[24:15], 3'd0, rnd[11:7], OP_ALS}, 1'b1);
            drive({f7, rnd[24:15], 3'd5, rnd[11:7], OP_ALS}, 1'b1);
            drive({f7, rnd[24:15], 3'd5, rnd[11:7], OP_ALSI}, 1'b1);
        end

        drive('0, 1'b0);
        repeat (2) @(negedge clk);  // Last result compared

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* id_stage.f */
common/rv_isa_pkg.sv
common/decode_pkg.sv
hw/decoder/imm_gen.sv
hw/decoder/ctrl_decode.sv
hw/decoder/operand_mux.sv
hw/id_ex_reg.sv
hw/id_stage.sv
test/tb_clock.sv
test/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  # Packages first, the decoder depends on both
  - common/rv_isa_pkg.sv
  - common/decode_pkg.sv
  - hw/decoder/imm_gen.sv
  - hw/decoder/ctrl_decode.sv
  - hw/decoder/operand_mux.sv
  - hw/id_ex_reg.sv
  - hw/id_stage.sv

  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_id_stage.sv
